/* rtl/fb_pkg.sv */
package fb_pkg;

	// ########################################################################
	// Pixel and bus data types
	// ########################################################################

	// One RGB pixel, blue in the low byte, red on top
	typedef logic [23:0] pixel_t;

	// Two pixels as stored in memory
	// Each sits in a 32-bit slot at bits 31..8, low byte unused
	typedef logic [63:0] pixel_pair_t;

	// One AXI read data beat, eight pixel slots
	typedef logic [255:0] beat_t;

	// Line or pixel coordinate
	typedef logic [11:0] coord_t;

	// Byte address on the memory bus
	typedef logic [28:0] axi_addr_t;

	// ########################################################################
	// Frame layout
	// ########################################################################

	// Pixels carried by one data beat
	localparam int PIXELS_PER_BEAT = 8;

	// Bytes taken by one pixel slot in memory
	localparam int BYTES_PER_PIXEL = 4;

	// ########################################################################
	// Fixed AXI read channel codes
	// ########################################################################

	// INCR burst type
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// 32 bytes per beat on the 256-bit data path
	localparam logic [2:0] AXI_SIZE_CODE = 3'b101;

	// Bufferable, modifiable
	localparam logic [3:0] AXI_CACHE_CODE = 4'b0011;

endpackage

/* rtl/fb_burst_reader.sv */
`timescale 1ns/1ns

module fb_burst_reader import fb_pkg::*; #(
	parameter int input_width = 3840,
	parameter int output_width = 1920,
	parameter int output_height = 1080,
	parameter int crop_xoffset = 1024,
	parameter int crop_yoffset = 540,
	parameter int burst_len = 16
)(
	input logic axi_clock,
	input logic global_reset,
	input logic output_vsync,
	input logic output_line_start,
	input logic zoom_mode,
	output axi_addr_t axi_araddr,
	output logic axi_arvalid,
	input logic axi_arready,
	input logic axi_rvalid,
	input logic axi_rlast,
	output logic buf_write,
	output logic buf_half,
	output coord_t buf_beat_index
);

	// Pixels moved by one burst
	localparam int burst_step = burst_len * PIXELS_PER_BEAT;
	// Bursts per line, crop reads output_width pixels, scale twice that
	localparam int crop_bursts = output_width / burst_step;
	localparam int scale_bursts = (2 * output_width) / burst_step;

	typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

	state_t state;
	coord_t fetch_line;
	coord_t next_line;
	coord_t bursts_left;
	axi_addr_t burst_pixel;
	axi_addr_t start_pixel;
	logic fetch_req;

	// ########################################################################
	// Line selection and start pixel
	// ########################################################################

	// vsync restarts at line 0, line_start steps to the following line
	assign next_line = output_vsync ? '0 : coord_t'(fetch_line + coord_t'(1));
	// Lines past the bottom of the display are not fetched
	assign fetch_req = output_vsync || (output_line_start && (next_line < output_height));

	always_comb begin
		if (zoom_mode) begin
			// Crop window at a fixed origin in the stored frame
			start_pixel = (axi_addr_t'(next_line) + axi_addr_t'(crop_yoffset))
				* axi_addr_t'(input_width) + axi_addr_t'(crop_xoffset);
		end else begin
			// Scale reads every second input row
			start_pixel = (axi_addr_t'(next_line) << 1) * axi_addr_t'(input_width);
		end
	end

	// ########################################################################
	// Burst FSM
	// ########################################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			state <= st_idle;
			fetch_line <= '0;
			buf_half <= 1'b0;
			buf_beat_index <= '0;
			bursts_left <= '0;
		end else begin
			// Track line number and target half on every display request
			if (output_vsync) begin
				fetch_line <= next_line;
				buf_half <= 1'b0;
			end else if (output_line_start) begin
				fetch_line <= next_line;
				buf_half <= ~buf_half;
			end
			case (state)
				st_idle: begin
					if (fetch_req) begin
						state <= st_addr;
						buf_beat_index <= '0;
						bursts_left <= coord_t'(zoom_mode ? crop_bursts : scale_bursts);
					end
				end
				st_addr: begin
					// Address held until the slave takes it
					if (axi_arready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (axi_rvalid) begin
						buf_beat_index <= coord_t'(buf_beat_index + coord_t'(1));
						if (axi_rlast) begin
							bursts_left <= coord_t'(bursts_left - coord_t'(1));
							state <= (bursts_left == coord_t'(1)) ? st_idle : st_addr;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Burst start pixel, loaded per line then stepped per burst
	always_ff @(posedge axi_clock) begin
		if (state == st_idle && fetch_req) begin
			burst_pixel <= start_pixel;
		end else if (state == st_data && axi_rvalid && axi_rlast) begin
			burst_pixel <= burst_pixel + axi_addr_t'(burst_step);
		end
	end

	assign axi_arvalid = (state == st_addr);
	assign axi_araddr = burst_pixel * axi_addr_t'(BYTES_PER_PIXEL);
	// rready is tied high, so every valid beat lands in the buffer
	assign buf_write = (state == st_data) && axi_rvalid;

	// Address channel stays up and steady until accepted
	assert property (@(posedge axi_clock) disable iff (global_reset)
		axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));

	// No read data without an outstanding burst
	assert property (@(posedge axi_clock) disable iff (global_reset)
		state == st_idle |-> !axi_rvalid);

endmodule

/* rtl/fb_line_buffer.sv */
`timescale 1ns/1ns

module fb_line_buffer import fb_pkg::*; (
	input logic axi_clock,
	input logic buf_write,
	input logic buf_half,
	input coord_t buf_beat_index,
	input beat_t axi_rdata,
	input logic buf_read_half,
	input coord_t buf_pair_index,
	output pixel_pair_t buf_pair
);

	// ########################################################################
	// Geometry
	// ########################################################################

	// 512 pixels per half
	localparam int half_pixels = 512;
	localparam int half_beats = half_pixels / PIXELS_PER_BEAT;
	localparam int beat_bits = $clog2(half_beats);
	// Pixel pairs packed in one beat
	localparam int pairs_per_beat = PIXELS_PER_BEAT / 2;
	localparam int pair_bits = $clog2(pairs_per_beat);
	localparam int pair_width = $bits(pixel_pair_t);

	// Half select on top, beat slot below
	beat_t line_ram [0:(2 * half_beats) - 1];

	logic [beat_bits:0] write_addr;
	logic [beat_bits:0] read_addr;
	logic [pair_bits-1:0] pair_sel;

	assign write_addr = {buf_half, buf_beat_index[beat_bits-1:0]};
	// Upper pair index bits pick the beat, low bits the pair inside it
	assign read_addr = {buf_read_half, buf_pair_index[pair_bits +: beat_bits]};
	assign pair_sel = buf_pair_index[pair_bits-1:0];

	// Whole beat written straight from the read data channel
	always_ff @(posedge axi_clock) begin
		if (buf_write) begin
			line_ram[write_addr] <= axi_rdata;
		end
	end

	// Registered read port, one cycle latency
	always_ff @(posedge axi_clock) begin
		buf_pair <= line_ram[read_addr][pair_sel * pair_width +: pair_width];
	end

	// Reader must never spill into the other half
	assert property (@(posedge axi_clock)
		buf_write |-> buf_beat_index < coord_t'(half_beats));

endmodule

/* rtl/fb_pixel_out.sv */
`timescale 1ns/1ns

module fb_pixel_out import fb_pkg::*; #(
	parameter int output_width = 1920
)(
	input logic axi_clock,
	input logic global_reset,
	input logic output_vsync,
	input logic output_line_start,
	input logic output_den,
	input logic zoom_mode,
	input pixel_pair_t buf_pair,
	output logic buf_read_half,
	output coord_t buf_pair_index,
	output pixel_t output_data,
	output logic output_valid
);

	coord_t pixel_x;
	logic odd_q;

	// Per channel mean of two pixels, rounded down
	function automatic pixel_t rgb_average(input pixel_t pixel_a, input pixel_t pixel_b);
		logic [8:0] sum;
		pixel_t avg;
		for (int ch = 0; ch < 3; ch++) begin
			sum = {1'b0, pixel_a[ch*8 +: 8]} + {1'b0, pixel_b[ch*8 +: 8]};
			avg[ch*8 +: 8] = sum[8:1];
		end
		return avg;
	endfunction

	// ########################################################################
	// Display position and half selection
	// ########################################################################

	always_ff @(posedge axi_clock) begin
		if (global_reset) begin
			pixel_x <= '0;
			buf_read_half <= 1'b1;
			output_valid <= 1'b0;
		end else begin
			if (output_vsync) begin
				// First line_start flips this to half 0, where line 0 lands
				pixel_x <= '0;
				buf_read_half <= 1'b1;
			end else if (output_line_start) begin
				pixel_x <= '0;
				buf_read_half <= ~buf_read_half;
			end else if (output_den) begin
				pixel_x <= coord_t'(pixel_x + coord_t'(1));
			end
			// Data returns with the RAM read, one cycle after den
			output_valid <= output_den;
		end
	end

	// Crop shows both slots of a pair, scale folds a pair into one pixel
	assign buf_pair_index = zoom_mode ? {1'b0, pixel_x[11:1]} : pixel_x;

	// Slot choice follows the RAM by one cycle
	always_ff @(posedge axi_clock) begin
		odd_q <= pixel_x[0];
	end

	// ########################################################################
	// Pixel formation
	// ########################################################################

	always_comb begin
		if (zoom_mode) begin
			output_data = odd_q ? buf_pair[63:40] : buf_pair[31:8];
		end else begin
			output_data = rgb_average(buf_pair[63:40], buf_pair[31:8]);
		end
	end

	// den only mid-line, and never past the displayed width
	assert property (@(posedge axi_clock) disable iff (global_reset)
		output_den |-> !output_line_start && !output_vsync && (pixel_x < output_width));

endmodule

/* rtl/fb_display_top.sv */
`timescale 1ns/1ns

module fb_display_top import fb_pkg::*; #(
	parameter int input_width = 3840,
	parameter int output_width = 1920,
	parameter int output_height = 1080,
	parameter int crop_xoffset = 1024,
	parameter int crop_yoffset = 540,
	parameter int burst_len = 16
)(
	input logic axi_clock,
	input logic global_reset,
	// Pixel side
	input logic output_vsync,
	input logic output_line_start,
	input logic output_den,
	input logic zoom_mode,
	output pixel_t output_data,
	output logic output_valid,
	// AXI4 read address
	output axi_addr_t axi_araddr,
	output logic [7:0] axi_arlen,
	output logic [2:0] axi_arsize,
	output logic [1:0] axi_arburst,
	output logic [3:0] axi_arcache,
	output logic axi_arvalid,
	input logic axi_arready,
	// AXI4 read data
	input beat_t axi_rdata,
	input logic axi_rvalid,
	input logic axi_rlast,
	output logic axi_rready
);

	logic buf_write;
	logic buf_half;
	coord_t buf_beat_index;
	logic buf_read_half;
	coord_t buf_pair_index;
	pixel_pair_t buf_pair;

	// ########################################################################
	// Fixed read channel fields
	// ########################################################################

	assign axi_arlen = 8'(burst_len - 1);
	assign axi_arsize = AXI_SIZE_CODE;
	assign axi_arburst = AXI_BURST_INCR;
	assign axi_arcache = AXI_CACHE_CODE;
	// Display side always sinks read data
	assign axi_rready = 1'b1;

	fb_burst_reader #(
		.input_width(input_width),
		.output_width(output_width),
		.output_height(output_height),
		.crop_xoffset(crop_xoffset),
		.crop_yoffset(crop_yoffset),
		.burst_len(burst_len)
	) reader_i (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.output_vsync(output_vsync),
		.output_line_start(output_line_start),
		.zoom_mode(zoom_mode),
		.axi_araddr(axi_araddr),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rvalid(axi_rvalid),
		.axi_rlast(axi_rlast),
		.buf_write(buf_write),
		.buf_half(buf_half),
		.buf_beat_index(buf_beat_index)
	);

	// Beat data goes straight from the bus into the RAM
	fb_line_buffer line_buffer_i (
		.axi_clock(axi_clock),
		.buf_write(buf_write),
		.buf_half(buf_half),
		.buf_beat_index(buf_beat_index),
		.axi_rdata(axi_rdata),
		.buf_read_half(buf_read_half),
		.buf_pair_index(buf_pair_index),
		.buf_pair(buf_pair)
	);

	fb_pixel_out #(
		.output_width(output_width)
	) pixel_out_i (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.output_vsync(output_vsync),
		.output_line_start(output_line_start),
		.output_den(output_den),
		.zoom_mode(zoom_mode),
		.buf_pair(buf_pair),
		.buf_read_half(buf_read_half),
		.buf_pair_index(buf_pair_index),
		.output_data(output_data),
		.output_valid(output_valid)
	);

endmodule

/* tb/fb_axi_mem.sv */
`timescale 1ns/1ns

module fb_axi_mem import fb_pkg::*; (
	input logic axi_clock,
	input logic global_reset,
	input axi_addr_t axi_araddr,
	input logic [7:0] axi_arlen,
	input logic axi_arvalid,
	output logic axi_arready,
	output beat_t axi_rdata,
	output logic axi_rvalid,
	output logic axi_rlast,
	input logic axi_rready,
	output int burst_count
);

	logic in_burst;
	logic [3:0] delay;
	logic [7:0] beats_left;
	axi_addr_t beat_addr;
	int seed;

	// Frame content, pixel p holds red p*7, green p*3, blue p
	// Each pixel in bits 31..8 of its 32-bit slot
	function automatic beat_t frame_beat(input axi_addr_t byte_addr);
		beat_t beat;
		int first;
		int p;
		beat = '0;
		first = int'(byte_addr) / BYTES_PER_PIXEL;
		for (int s = 0; s < PIXELS_PER_BEAT; s++) begin
			p = first + s;
			beat[s*32+8 +: 24] = {8'(p * 7), 8'(p * 3), 8'(p)};
		end
		return beat;
	endfunction

	initial begin
		seed = 32'hf063;
		axi_arready = 1'b0;
		axi_rvalid = 1'b0;
		axi_rlast = 1'b0;
		axi_rdata = '0;
		burst_count = 0;
	end

	// ########################################################################
	// Read slave with random stalls
	// ########################################################################

	always @(posedge axi_clock) begin
		if (global_reset) begin
			axi_arready <= 1'b0;
			axi_rvalid <= 1'b0;
			axi_rlast <= 1'b0;
			axi_rdata <= '0;
			burst_count <= 0;
			in_burst <= 1'b0;
			delay <= 4'd0;
			beats_left <= 8'd0;
			beat_addr <= '0;
		end else if (!in_burst) begin
			if (axi_arvalid && axi_arready) begin
				// Address taken, first beat after a short stall
				axi_arready <= 1'b0;
				in_burst <= 1'b1;
				beat_addr <= axi_araddr;
				beats_left <= axi_arlen;
				delay <= 4'({$random(seed)} % 4);
			end else if (axi_arvalid) begin
				if (delay == 4'd0) begin
					axi_arready <= 1'b1;
				end else begin
					delay <= delay - 4'd1;
				end
			end
		end else if (axi_rvalid) begin
			if (axi_rready) begin
				// Beat accepted, gap before the next one
				axi_rvalid <= 1'b0;
				axi_rlast <= 1'b0;
				beat_addr <= beat_addr + axi_addr_t'(PIXELS_PER_BEAT * BYTES_PER_PIXEL);
				beats_left <= beats_left - 8'd1;
				delay <= 4'({$random(seed)} % 4);
				if (axi_rlast) begin
					in_burst <= 1'b0;
					burst_count <= burst_count + 1;
				end
			end
		end else if (delay == 4'd0) begin
			axi_rvalid <= 1'b1;
			axi_rdata <= frame_beat(beat_addr);
			axi_rlast <= (beats_left == 8'd0);
		end else begin
			delay <= delay - 4'd1;
		end
	end

endmodule

/* tb/fb_tb.sv */
`timescale 1ns/1ns

module fb_tb import fb_pkg::*; ();

	localparam int in_width = 64;
	localparam int out_width = 16;
	localparam int out_height = 4;
	localparam int crop_x = 8;
	localparam int crop_y = 2;
	localparam int burst_beats = 2;
	localparam int wait_limit = 200;
	localparam int frame_count = 4;
	// Bursts per line, one for a crop line, two for a scale line
	localparam int crop_bursts = 1;
	localparam int scale_bursts = 2;

	logic axi_clock;
	logic global_reset;
	logic output_vsync;
	logic output_line_start;
	logic output_den;
	logic zoom_mode;
	pixel_t output_data;
	logic output_valid;
	axi_addr_t axi_araddr;
	logic [7:0] axi_arlen;
	logic [2:0] axi_arsize;
	logic [1:0] axi_arburst;
	logic [3:0] axi_arcache;
	logic axi_arvalid;
	logic axi_arready;
	beat_t axi_rdata;
	logic axi_rvalid;
	logic axi_rlast;
	logic axi_rready;
	int burst_count;

	// Stimulus table, one row per frame
	// Zoom mode (1 crop, 0 scale) and the largest idle gap between den strobes
	logic frame_zoom [0:frame_count-1] = '{1'b1, 1'b0, 1'b1, 1'b0};
	int frame_gap [0:frame_count-1] = '{0, 0, 3, 2};

	int errors;
	int seed;
	logic den_q;
	pixel_t pixel_q;
	axi_addr_t addr_seen [$];

	fb_display_top #(
		.input_width(in_width),
		.output_width(out_width),
		.output_height(out_height),
		.crop_xoffset(crop_x),
		.crop_yoffset(crop_y),
		.burst_len(burst_beats)
	) dut_i (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.output_vsync(output_vsync),
		.output_line_start(output_line_start),
		.output_den(output_den),
		.zoom_mode(zoom_mode),
		.output_data(output_data),
		.output_valid(output_valid),
		.axi_araddr(axi_araddr),
		.axi_arlen(axi_arlen),
		.axi_arsize(axi_arsize),
		.axi_arburst(axi_arburst),
		.axi_arcache(axi_arcache),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rdata(axi_rdata),
		.axi_rvalid(axi_rvalid),
		.axi_rlast(axi_rlast),
		.axi_rready(axi_rready)
	);

	fb_axi_mem mem_i (
		.axi_clock(axi_clock),
		.global_reset(global_reset),
		.axi_araddr(axi_araddr),
		.axi_arlen(axi_arlen),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rdata(axi_rdata),
		.axi_rvalid(axi_rvalid),
		.axi_rlast(axi_rlast),
		.axi_rready(axi_rready),
		.burst_count(burst_count)
	);

	initial begin
		axi_clock = 1'b0;
		forever #5 axi_clock = ~axi_clock;
	end

	// Record every accepted read address and check the fixed request fields
	always @(posedge axi_clock) begin
		if (!global_reset && axi_arvalid && axi_arready) begin
			addr_seen.push_back(axi_araddr);
			compare_code("axi_arlen", axi_arlen, 8'(burst_beats - 1));
			// 32-byte beats, size code is log2 of the beat bytes
			compare_code("axi_arsize", 8'(axi_arsize), 8'd5);
			// INCR burst type
			compare_code("axi_arburst", 8'(axi_arburst), 8'd1);
			compare_code("axi_arcache", 8'(axi_arcache), 8'(AXI_CACHE_CODE));
			compare_bit("axi_rready", axi_rready, 1'b1);
		end
	end

	// ########################################################################
	// Compare tasks and expected values
	// ########################################################################

	task automatic compare_pixel(input string name, input pixel_t actual, input pixel_t expected);
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %06h, expected %06h", $time, name, actual, expected);
		end
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic compare_addr(input string name, input axi_addr_t actual,
		input axi_addr_t expected);
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic compare_code(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic compare_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Stored frame pixel, red p*7, green p*3, blue p
	function automatic pixel_t model_pixel(input int p);
		return {8'(p * 7), 8'(p * 3), 8'(p)};
	endfunction

	function automatic pixel_t expected_pixel(input logic crop, input int y, input int x);
		pixel_t left;
		pixel_t right;
		pixel_t mean;
		int first;
		if (crop) begin
			mean = model_pixel((y + crop_y) * in_width + crop_x + x);
		end else begin
			// Neighbour pair from every second input row, halved per channel
			first = 2 * y * in_width + 2 * x;
			left = model_pixel(first);
			right = model_pixel(first + 1);
			for (int ch = 0; ch < 3; ch++) begin
				mean[ch*8 +: 8] = 8'((int'(left[ch*8 +: 8]) + int'(right[ch*8 +: 8])) / 2);
			end
		end
		return mean;
	endfunction

	// ########################################################################
	// Stimulus
	// ########################################################################

	// One clock: check last cycle's pixel port, then drive the strobes
	task automatic step_cycle(input logic vsync, input logic line_start, input logic den,
		input pixel_t expect_px);
		@(negedge axi_clock);
		compare_bit("output_valid", output_valid, den_q);
		if (den_q) begin
			compare_pixel("output_data", output_data, pixel_q);
		end
		output_vsync = vsync;
		output_line_start = line_start;
		output_den = den;
		den_q = den;
		pixel_q = expect_px;
	endtask

	// Wait until line y sits in the buffer, then check its burst addresses
	task automatic await_line_fetch(input logic crop, input int y, input int target,
		output logic hung);
		int waited;
		int bursts;
		axi_addr_t line_addr;
		waited = 0;
		hung = 1'b0;
		bursts = crop ? crop_bursts : scale_bursts;
		while (burst_count < target) begin
			if (waited == wait_limit) begin
				errors++;
				$display("Timeout: fetch of line %0d not done after %0d cycles", y, wait_limit);
				hung = 1'b1;
				return;
			end
			step_cycle(1'b0, 1'b0, 1'b0, '0);
			waited++;
		end
		compare_count("burst_count", burst_count, target);
		if (crop) begin
			line_addr = axi_addr_t'(((y + crop_y) * in_width + crop_x) * 4);
		end else begin
			line_addr = axi_addr_t'(2 * y * in_width * 4);
		end
		for (int b = 0; b < bursts; b++) begin
			if (addr_seen.size() == 0) begin
				errors++;
				$display("No read address was issued for burst %0d of line %0d", b, y);
			end else begin
				compare_addr("axi_araddr", addr_seen.pop_front(), line_addr + axi_addr_t'(64 * b));
			end
		end
	endtask

	task automatic play_frames(output int target, output logic hung);
		int gap;
		target = 0;
		hung = 1'b0;
		for (int f = 0; f < frame_count; f++) begin
			// Mode changes only between frames
			step_cycle(1'b0, 1'b0, 1'b0, '0);
			zoom_mode = frame_zoom[f];
			step_cycle(1'b1, 1'b0, 1'b0, '0);
			for (int y = 0; y < out_height; y++) begin
				target += frame_zoom[f] ? crop_bursts : scale_bursts;
				await_line_fetch(frame_zoom[f], y, target, hung);
				if (hung) begin
					return;
				end
				step_cycle(1'b0, 1'b1, 1'b0, '0);
				for (int x = 0; x < out_width; x++) begin
					gap = (frame_gap[f] == 0) ? 0 : {$random(seed)} % (frame_gap[f] + 1);
					repeat (gap) step_cycle(1'b0, 1'b0, 1'b0, '0);
					step_cycle(1'b0, 1'b0, 1'b1, expected_pixel(frame_zoom[f], y, x));
				end
			end
		end
	endtask

	initial begin
		logic hung;
		int total;
		errors = 0;
		seed = 32'hf063;
		den_q = 1'b0;
		pixel_q = '0;
		global_reset = 1'b1;
		output_vsync = 1'b0;
		output_line_start = 1'b0;
		output_den = 1'b0;
		zoom_mode = 1'b1;
		repeat (4) @(negedge axi_clock);
		global_reset = 1'b0;
		// Quiet bus and pixel port until the first request
		for (int i = 0; i < 8; i++) begin
			step_cycle(1'b0, 1'b0, 1'b0, '0);
			compare_bit("axi_arvalid", axi_arvalid, 1'b0);
		end
		play_frames(total, hung);
		if (!hung) begin
			// No stray fetch after the last line of the last frame
			repeat (20) step_cycle(1'b0, 1'b0, 1'b0, '0);
			compare_count("burst_count", burst_count, total);
			if (addr_seen.size() != 0) begin
				errors++;
				$display("%0d read addresses were issued beyond the expected ones", addr_seen.size());
			end
		end
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
rtl/fb_pkg.sv
rtl/fb_burst_reader.sv
rtl/fb_line_buffer.sv
rtl/fb_pixel_out.sv
rtl/fb_display_top.sv
tb/fb_axi_mem.sv
tb/fb_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= fb_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: lint sim clean

# Lint the whole project, testbench included
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; fail unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
